/* exec_top.f */
exec_pkg.sv
alu.sv
stage_reg.sv
hazard_unit.sv
exec.sv
exec_top.sv
tb_clock.sv
tb_exec_top.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_exec_top
RTL_TOP  = exec_top
FILELIST = exec_top.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "=== FAIL ===" $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(RTL_TOP) exec_pkg.sv alu.sv stage_reg.sv \
		hazard_unit.sv exec.sv exec_top.sv

clean:
	rm -rf obj_dir $(LOG)

/* tb_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top import exec_pkg::*; ();

    // instruction flag bits
    localparam logic [7:0] F_IMM = 8'h80;
    localparam logic [7:0] F_PC  = 8'h40;
    localparam logic [7:0] F_BR  = 8'h20;
    localparam logic [7:0] F_JMP = 8'h10;
    localparam logic [7:0] F_INV = 8'h08;
    localparam logic [7:0] F_ST  = 8'h04;
    localparam logic [7:0] F_LD  = 8'h02;
    localparam logic [7:0] F_WR  = 8'h01;

    logic clk, rst_n;
    logic in_valid, in_ready, in_alu_src, in_src_a_pc, in_branch, in_jump, in_funct3_0;
    logic in_mem_write, in_mem_read, in_reg_write, wb_valid, redirect;
    logic [31:0] in_pc, in_rd1, in_rd2, in_imm, wb_result, redirect_target;
    logic [4:0] in_rs1, in_rs2, in_rd, wb_rd, mem_rd;
    logic [3:0] in_alu_control;
    logic [1:0] in_result_src, mem_result_src;
    logic mem_valid, mem_we, mem_re, mem_reg_write;
    logic [31:0] mem_addr, mem_wdata, mem_result;

    logic [31:0] regs [32];
    logic [31:0] arch [32];
    logic [31:0] lfsr_state = 32'he6812375;
    logic [31:0] pc = 32'h1000;
    logic [31:0] q_result [$];
    logic [31:0] q_addr [$];
    logic [31:0] q_wdata [$];
    logic [9:0]  q_ctl [$];
    int q_due [$];
    int negedge_count = 0;
    logic ex_pending = 1'b0;
    logic exp_redirect;
    logic [31:0] exp_target;
    logic pend_v = 1'b0;
    logic [4:0] pend_rd;
    logic [31:0] pend_val;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    exec_top u_dut (.*);

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic lsb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) lfsr_state = lfsr_state ^ 32'ha3000000;
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    // data memory contents as a function of the whole address
    function automatic logic [31:0] load_value(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hc3a596e1;
    endfunction

    function automatic logic [31:0] model_alu(input logic [3:0] op, input logic [31:0] a, b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SRL:  return a >> b[4:0];
            ALU_SLTU: return {31'b0, a < b};
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            default:  return '0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic fail_msg(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // called at a rising edge and returns at the edge that accepts the instruction
    task automatic send(input logic [3:0] op, input logic [4:0] s1, s2, d,
                        input logic [31:0] im, input logic [7:0] flags,
                        input logic [1:0] rsrc, input logic keep,
                        output int stalls, output logic taken);
        logic r;
        logic cond;
        logic [31:0] a, b, res, link;
        in_valid <= 1'b1;
        in_pc <= pc;
        in_rd1 <= regs[s1];
        in_rd2 <= regs[s2];
        in_imm <= im;
        in_rs1 <= s1;
        in_rs2 <= s2;
        in_rd <= d;
        in_alu_control <= op;
        {in_alu_src, in_src_a_pc, in_branch, in_jump} <= flags[7:4];
        {in_funct3_0, in_mem_write, in_mem_read, in_reg_write} <= flags[3:0];
        in_result_src <= rsrc;
        stalls = 0;
        r = 1'b0;
        while (!r) begin
            @(negedge clk);
            r = in_ready;
            @(posedge clk);
            if (!r) begin
                stalls++;
                if (stalls > 20) fail_msg("timed out waiting for in_ready");
            end
        end
        a = flags[6] ? pc : arch[s1];
        b = flags[7] ? im : arch[s2];
        res = model_alu(op, a, b);
        link = pc + 32'd4;
        case (op)
            ALU_SUB:           cond = (res == 0);
            ALU_SLT, ALU_SLTU: cond = res[0];
            default:           cond = 1'b0;
        endcase
        taken = (flags[5] && (cond ^ flags[3])) || flags[4];
        if (keep) begin
            ex_pending = 1'b1;
            exp_redirect = taken;
            exp_target = flags[4] ? res : pc + im;
            q_result.push_back((rsrc == RES_PC4) ? link : res);
            q_addr.push_back(arch[s1] + im);
            q_wdata.push_back(arch[s2]);
            q_ctl.push_back({rsrc, flags[2], flags[1], flags[0], d});
            // MEM is due two edges after acceptance
            q_due.push_back(negedge_count + 2);
            if (flags[0] && d != 0) begin
                if (rsrc == RES_MEM) arch[d] = load_value(arch[s1] + im);
                else arch[d] = (rsrc == RES_PC4) ? link : res;
            end
        end else begin
            taken = 1'b0;
        end
        pc = pc + 32'd4;
    endtask

    task automatic idle_and_drain();
        int n;
        in_valid <= 1'b0;
        n = 0;
        while (q_result.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 20) fail_msg("timed out waiting for mem_valid");
        end
        @(posedge clk);
    endtask

    // model regfile written at the negedge before the wb ports move
    always @(negedge clk) begin
        pend_v = 1'b0;
        if (rst_n && mem_valid && mem_reg_write) begin
            pend_v = 1'b1;
            pend_rd = mem_rd;
            pend_val = mem_re ? load_value(mem_addr) : mem_result;
            if (mem_rd != 0) regs[mem_rd] = pend_val;
        end
    end

    always @(posedge clk) begin
        wb_valid <= pend_v;
        wb_rd <= pend_rd;
        wb_result <= pend_val;
    end

    always @(negedge clk) begin
        negedge_count++;
        if (rst_n) begin
            if (ex_pending) begin
                check("redirect", {31'b0, redirect}, {31'b0, exp_redirect});
                if (exp_redirect) check("redirect_target", redirect_target, exp_target);
                ex_pending = 1'b0;
            end else begin
                check("redirect", {31'b0, redirect}, 32'd0);
            end
            if (mem_valid) begin
                if (q_result.size() == 0) fail_msg("a discarded instruction reached MEM");
                check("mem_valid cycle", negedge_count, q_due.pop_front());
                check("mem_result", mem_result, q_result.pop_front());
                check("mem_addr", mem_addr, q_addr.pop_front());
                check("mem_wdata", mem_wdata, q_wdata.pop_front());
                check("mem_result_src/we/re/reg_write/rd",
                      {22'b0, mem_result_src, mem_we, mem_re, mem_reg_write, mem_rd},
                      {22'b0, q_ctl.pop_front()});
            end
        end
    end

    task automatic test_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) fail_msg("reset never released");
        end
        @(negedge clk);
        check("mem_valid", {31'b0, mem_valid}, 32'd0);
        check("mem_we", {31'b0, mem_we}, 32'd0);
        check("mem_re", {31'b0, mem_re}, 32'd0);
        check("mem_reg_write", {31'b0, mem_reg_write}, 32'd0);
        check("redirect", {31'b0, redirect}, 32'd0);
        check("in_ready", {31'b0, in_ready}, 32'd1);
        @(posedge clk);
    endtask

    task automatic test_alu();
        logic [3:0] ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_XOR, ALU_SLT,
                                 ALU_SRL, ALU_SLTU, ALU_OR, ALU_AND, ALU_SRA};
        int st;
        logic tk;
        for (int i = 0; i < 10; i++) begin
            send(ops[i], 1, 2, 11, lfsr_bits(32), F_WR, RES_ALU, 1, st, tk);
            send(ops[i], 3, 4, 12, lfsr_bits(32), F_IMM | F_WR, RES_ALU, 1, st, tk);
        end
        idle_and_drain();
    endtask

    task automatic test_forwarding();
        int st;
        logic tk;
        send(ALU_ADD, 1, 2, 5, 0, F_WR, RES_ALU, 1, st, tk);
        send(ALU_ADD, 5, 3, 6, 0, F_WR, RES_ALU, 1, st, tk);
        send(ALU_ADD, 1, 3, 7, 0, F_WR, RES_ALU, 1, st, tk);
        send(ALU_ADD, 2, 2, 8, 0, F_WR, RES_ALU, 1, st, tk);
        send(ALU_SUB, 4, 7, 9, 0, F_WR, RES_ALU, 1, st, tk);
        // MEM and WB both hold x13
        send(ALU_ADD, 1, 2, 13, 0, F_WR, RES_ALU, 1, st, tk);
        send(ALU_OR, 3, 4, 13, 0, F_WR, RES_ALU, 1, st, tk);
        send(ALU_AND, 13, 1, 14, 0, F_WR, RES_ALU, 1, st, tk);
        // x0 stays zero
        send(ALU_ADD, 1, 2, 0, 0, F_WR, RES_ALU, 1, st, tk);
        send(ALU_ADD, 0, 3, 15, 0, F_WR, RES_ALU, 1, st, tk);
        send(ALU_ADD, 4, 0, 16, 0, F_WR, RES_ALU, 1, st, tk);
        idle_and_drain();
    endtask

    task automatic test_load_use();
        int st;
        logic tk;
        send(ALU_ADD, 1, 0, 17, 32'h24, F_IMM | F_LD | F_WR, RES_MEM, 1, st, tk);
        send(ALU_ADD, 17, 2, 18, 0, F_WR, RES_ALU, 1, st, tk);
        check("stall cycles", st, 1);
        idle_and_drain();
    endtask

    task automatic test_branches();
        logic [3:0] bops [6] = '{ALU_SUB, ALU_SUB, ALU_SLT, ALU_SLT, ALU_SLTU, ALU_SLTU};
        logic [4:0] ra [3] = '{3, 3, 4};
        logic [4:0] rb [3] = '{3, 4, 3};
        int st;
        logic tk;
        logic tk2;
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                send(bops[k], ra[p], rb[p], 0, 32'h40, F_BR | ((k % 2) ? F_INV : 8'h0),
                     RES_ALU, 1, st, tk);
                send(ALU_ADD, 1, 0, 19, 32'h10, F_IMM | F_WR, RES_ALU, !tk, st, tk2);
                idle_and_drain();
            end
        end
        send(ALU_ADD, 0, 0, 21, 32'h100, F_IMM | F_PC | F_JMP | F_WR, RES_PC4, 1, st, tk);
        send(ALU_ADD, 1, 0, 20, 32'h8, F_IMM | F_WR, RES_ALU, 0, st, tk2);
        idle_and_drain();
    endtask

    task automatic test_mem();
        int st;
        logic tk;
        send(ALU_ADD, 1, 0, 22, lfsr_bits(16), F_IMM | F_WR, RES_ALU, 1, st, tk);
        send(ALU_ADD, 3, 22, 0, 32'h1c, F_IMM | F_ST, RES_ALU, 1, st, tk);
        send(ALU_ADD, 22, 0, 23, 32'h8, F_IMM | F_LD | F_WR, RES_MEM, 1, st, tk);
        send(ALU_ADD, 2, 4, 0, 32'hfffffffc, F_IMM | F_ST, RES_ALU, 1, st, tk);
        idle_and_drain();
    endtask

    initial begin
        logic [31:0] v;
        {in_valid, in_alu_src, in_src_a_pc, in_branch, in_jump, in_funct3_0} = '0;
        {in_mem_write, in_mem_read, in_reg_write, in_result_src} = '0;
        {in_pc, in_rd1, in_rd2, in_imm, in_rs1, in_rs2, in_rd, in_alu_control} = '0;
        {wb_valid, wb_rd, wb_result} = '0;
        for (int i = 0; i < 32; i++) begin
            v = (i == 0) ? 32'h0 : lfsr_bits(32);
            regs[i] = v;
            arch[i] = v;
        end
        test_reset();
        test_alu();
        test_forwarding();
        test_load_use();
        test_branches();
        test_mem();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for four rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // decode side
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [XLEN-1:0]       in_pc,
    input  logic [XLEN-1:0]       in_rd1,
    input  logic [XLEN-1:0]       in_rd2,
    input  logic [XLEN-1:0]       in_imm,
    input  logic [REG_ADDR_W-1:0] in_rs1,
    input  logic [REG_ADDR_W-1:0] in_rs2,
    input  logic [REG_ADDR_W-1:0] in_rd,
    input  logic [3:0]            in_alu_control,
    input  logic                  in_alu_src,
    input  logic                  in_src_a_pc,
    input  logic                  in_branch,
    input  logic                  in_jump,
    input  logic                  in_funct3_0,
    input  logic                  in_mem_write,
    input  logic                  in_mem_read,
    input  logic                  in_reg_write,
    input  logic [1:0]            in_result_src,
    // write-back
    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_result,
    // redirect from EX
    output logic                  redirect,
    output logic [XLEN-1:0]       redirect_target,
    // MEM stage
    output logic                  mem_valid,
    output logic [XLEN-1:0]       mem_addr,
    output logic [XLEN-1:0]       mem_wdata,
    output logic                  mem_we,
    output logic                  mem_re,
    output logic [REG_ADDR_W-1:0] mem_rd,
    output logic                  mem_reg_write,
    output logic [1:0]            mem_result_src,
    output logic [XLEN-1:0]       mem_result
);

    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    logic    ex_valid;
    logic    load_use;
    logic    accept;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;

    assign in_ready = !load_use;
    // a stalled beat enters EX as a bubble
    assign accept   = in_valid && in_ready;

    assign id_ex_d = '{
        pc: in_pc, rd1: in_rd1, rd2: in_rd2, imm: in_imm,
        rs1: in_rs1, rs2: in_rs2, rd: in_rd,
        alu_control: in_alu_control, alu_src: in_alu_src, src_a_pc: in_src_a_pc,
        branch: in_branch, jump: in_jump, funct3_0: in_funct3_0,
        mem_write: in_mem_write, mem_read: in_mem_read,
        reg_write: in_reg_write, result_src: in_result_src
    };

    // redirect drops the instruction accepted behind it
    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect),
        .in_valid  (accept),
        .in_data   (id_ex_d),
        .out_valid (ex_valid),
        .out_data  (id_ex_q)
    );

    hazard_unit u_hazard (
        .ex_valid       (ex_valid),
        .ex_rs1         (id_ex_q.rs1),
        .ex_rs2         (id_ex_q.rs2),
        .ex_rd          (id_ex_q.rd),
        .ex_mem_read    (id_ex_q.mem_read),
        .mem_valid      (mem_valid),
        .mem_rd         (mem_rd),
        .mem_reg_write  (mem_reg_write),
        .mem_result_src (mem_result_src),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .dec_valid      (in_valid),
        .dec_rs1        (in_rs1),
        .dec_rs2        (in_rs2),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .load_use       (load_use)
    );

    exec u_exec (
        .ex_valid        (ex_valid),
        .pc              (id_ex_q.pc),
        .rd1             (id_ex_q.rd1),
        .rd2             (id_ex_q.rd2),
        .imm             (id_ex_q.imm),
        .rs1             (id_ex_q.rs1),
        .rs2             (id_ex_q.rs2),
        .rd              (id_ex_q.rd),
        .alu_control     (id_ex_q.alu_control),
        .alu_src         (id_ex_q.alu_src),
        .src_a_pc        (id_ex_q.src_a_pc),
        .branch          (id_ex_q.branch),
        .jump            (id_ex_q.jump),
        .funct3_0        (id_ex_q.funct3_0),
        .mem_write       (id_ex_q.mem_write),
        .mem_read        (id_ex_q.mem_read),
        .reg_write       (id_ex_q.reg_write),
        .result_src      (id_ex_q.result_src),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .mem_alu_result  (ex_mem_q.alu_result),
        .mem_pc_plus4    (ex_mem_q.pc_plus4),
        .mem_result_src  (ex_mem_q.result_src),
        .wb_result       (wb_result),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .em_alu_result   (ex_mem_d.alu_result),
        .em_addr         (ex_mem_d.addr),
        .em_wdata        (ex_mem_d.wdata),
        .em_pc_plus4     (ex_mem_d.pc_plus4),
        .em_rd           (ex_mem_d.rd),
        .em_reg_write    (ex_mem_d.reg_write),
        .em_mem_write    (ex_mem_d.mem_write),
        .em_mem_read     (ex_mem_d.mem_read),
        .em_result_src   (ex_mem_d.result_src)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (1'b0),
        .in_valid  (ex_valid),
        .in_data   (ex_mem_d),
        .out_valid (mem_valid),
        .out_data  (ex_mem_q)
    );

    // strobes qualified by valid
    assign mem_we         = mem_valid && ex_mem_q.mem_write;
    assign mem_re         = mem_valid && ex_mem_q.mem_read;
    assign mem_reg_write  = mem_valid && ex_mem_q.reg_write;
    assign mem_addr       = ex_mem_q.addr;
    assign mem_wdata      = ex_mem_q.wdata;
    assign mem_rd         = ex_mem_q.rd;
    assign mem_result_src = ex_mem_q.result_src;
    assign mem_result     = (ex_mem_q.result_src == RES_PC4) ? ex_mem_q.pc_plus4
                                                             : ex_mem_q.alu_result;

endmodule

`default_nettype wire

/* exec.sv */
`timescale 1ns/1ps
`default_nettype none

module exec import exec_pkg::*; (
    input  logic                  ex_valid,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       rd1,
    input  logic [XLEN-1:0]       rd2,
    input  logic [XLEN-1:0]       imm,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [3:0]            alu_control,
    input  logic                  alu_src,
    input  logic                  src_a_pc,
    input  logic                  branch,
    input  logic                  jump,
    input  logic                  funct3_0,
    input  logic                  mem_write,
    input  logic                  mem_read,
    input  logic                  reg_write,
    input  logic [1:0]            result_src,
    input  logic [1:0]            fwd_a,
    input  logic [1:0]            fwd_b,
    input  logic [XLEN-1:0]       mem_alu_result,
    input  logic [XLEN-1:0]       mem_pc_plus4,
    input  logic [1:0]            mem_result_src,
    input  logic [XLEN-1:0]       wb_result,
    output logic                  redirect,
    output logic [XLEN-1:0]       redirect_target,
    output logic [XLEN-1:0]       em_alu_result,
    output logic [XLEN-1:0]       em_addr,
    output logic [XLEN-1:0]       em_wdata,
    output logic [XLEN-1:0]       em_pc_plus4,
    output logic [REG_ADDR_W-1:0] em_rd,
    output logic                  em_reg_write,
    output logic                  em_mem_write,
    output logic                  em_mem_read,
    output logic [1:0]            em_result_src
);

    logic [XLEN-1:0] mem_value;
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;
    logic            zero;
    logic            cond_met;

    // value the MEM instruction will write back
    assign mem_value = (mem_result_src == RES_PC4) ? mem_pc_plus4 : mem_alu_result;

    function automatic logic [XLEN-1:0] fwd_mux(
        input logic [1:0]      sel,
        input logic [XLEN-1:0] reg_value
    );
        logic [XLEN-1:0] value;
        case (sel)
            FWD_MEM: value = mem_value;
            FWD_WB:  value = wb_result;
            default: value = reg_value;
        endcase
        return value;
    endfunction

    assign rs1_value = fwd_mux(fwd_a, rd1);
    assign rs2_value = fwd_mux(fwd_b, rd2);

    assign src_a = src_a_pc ? pc : rs1_value;
    assign src_b = alu_src ? imm : rs2_value;

    alu u_alu (
        .a           (src_a),
        .b           (src_b),
        .alu_control (alu_control),
        .result      (alu_result),
        .zero        (zero)
    );

    // funct3 bit 0 turns beq/blt/bltu into bne/bge/bgeu
    always_comb begin
        case (alu_control)
            ALU_SUB:  cond_met = zero ^ funct3_0;
            ALU_SLT:  cond_met = alu_result[0] ^ funct3_0;
            ALU_SLTU: cond_met = alu_result[0] ^ funct3_0;
            default:  cond_met = 1'b0;
        endcase
    end

    assign redirect        = ex_valid && ((branch && cond_met) || jump);
    assign redirect_target = jump ? alu_result : (pc + imm);

    // separate adder keeps the address off the ALU source muxes
    assign em_alu_result = alu_result;
    assign em_addr       = rs1_value + imm;
    assign em_wdata      = rs2_value;
    assign em_pc_plus4   = pc + XLEN'(4);

    assign em_rd         = rd;
    assign em_reg_write  = reg_write;
    assign em_mem_write  = mem_write;
    assign em_mem_read   = mem_read;
    assign em_result_src = result_src;

    always_comb begin
        if (ex_valid) begin
            assert final (!(mem_read && mem_write))
                else $error("exec: load and store set together, rs1=%0d rs2=%0d", rs1, rs2);
        end
    end

endmodule

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import exec_pkg::*; (
    input  logic                  ex_valid,
    input  logic [REG_ADDR_W-1:0] ex_rs1,
    input  logic [REG_ADDR_W-1:0] ex_rs2,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic                  ex_mem_read,
    input  logic                  mem_valid,
    input  logic [REG_ADDR_W-1:0] mem_rd,
    input  logic                  mem_reg_write,
    input  logic [1:0]            mem_result_src,
    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic                  dec_valid,
    input  logic [REG_ADDR_W-1:0] dec_rs1,
    input  logic [REG_ADDR_W-1:0] dec_rs2,
    output logic [1:0]            fwd_a,
    output logic [1:0]            fwd_b,
    output logic                  load_use
);

    logic mem_can_fwd;
    logic wb_can_fwd;

    // a load in MEM has no data yet and never forwards
    assign mem_can_fwd = mem_valid && mem_reg_write && (mem_result_src != RES_MEM)
                         && (mem_rd != '0);
    assign wb_can_fwd  = wb_valid && (wb_rd != '0);

    function automatic logic [1:0] pick_fwd(input logic [REG_ADDR_W-1:0] rs);
        logic [1:0] sel;
        sel = FWD_REG;
        if (mem_can_fwd && (mem_rd == rs)) begin
            sel = FWD_MEM;
        end else if (wb_can_fwd && (wb_rd == rs)) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_fwd(ex_rs1);
        fwd_b = pick_fwd(ex_rs2);
    end

    // decode consumer of a load still in EX needs one bubble
    assign load_use = ex_valid && ex_mem_read && (ex_rd != '0) && dec_valid
                      && ((dec_rs1 == ex_rd) || (dec_rs2 == ex_rd));

endmodule

`default_nettype wire

/* stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid cleared by reset or flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload only moves with a valid beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    ) else $error("stage_reg: out_valid unknown after reset");

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import exec_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [3:0]      alu_control,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_control)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SLTU: begin
                result = (a < b) ? XLEN'(1) : '0;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_SRA: begin
                // arithmetic shift keeps the sign
                result = $unsigned($signed(a) >>> shamt);
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // beq/bne use this through ALU_SUB
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // alu_control encodings shared with branch resolution
    localparam logic [3:0] ALU_ADD  = 4'b0000;
    localparam logic [3:0] ALU_SUB  = 4'b0001;
    localparam logic [3:0] ALU_SLL  = 4'b0010;
    localparam logic [3:0] ALU_XOR  = 4'b0100;
    localparam logic [3:0] ALU_SLT  = 4'b0101;
    localparam logic [3:0] ALU_SRL  = 4'b0110;
    localparam logic [3:0] ALU_SLTU = 4'b0111;
    localparam logic [3:0] ALU_OR   = 4'b1000;
    localparam logic [3:0] ALU_AND  = 4'b1001;
    localparam logic [3:0] ALU_SRA  = 4'b1110;

    // operand forwarding selects
    localparam logic [1:0] FWD_REG = 2'b00;
    localparam logic [1:0] FWD_MEM = 2'b01;
    localparam logic [1:0] FWD_WB  = 2'b10;

    // result source of an instruction
    localparam logic [1:0] RES_ALU = 2'b00;
    localparam logic [1:0] RES_MEM = 2'b01;
    localparam logic [1:0] RES_PC4 = 2'b10;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [3:0]            alu_control;
        logic                  alu_src;
        logic                  src_a_pc;
        logic                  branch;
        logic                  jump;
        // inverts the branch condition
        logic                  funct3_0;
        logic                  mem_write;
        logic                  mem_read;
        logic                  reg_write;
        logic [1:0]            result_src;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       pc_plus4;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic                  mem_write;
        logic                  mem_read;
        logic [1:0]            result_src;
    } ex_mem_t;

endpackage

`default_nettype wire
